/* Bender.yml */
package:
  name: uart_host_bridge

sources:
  - hw/uart_pkg.sv
  - hw/host_proto_pkg.sv
  - hw/uart_rx.sv
  - hw/uart_tx.sv
  - hw/tx_char_fifo.sv
  - hw/hex_cmd_parser.sv
  - hw/hex_rsp_encoder.sv
  - hw/uart_host_bridge.sv
  - target: test
    files:
      - tb/uart_host_bridge_assertions.sv
      - tb/tb_uart_host_bridge.sv

/* compile.f */
hw/uart_pkg.sv
hw/host_proto_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/tx_char_fifo.sv
hw/hex_cmd_parser.sv
hw/hex_rsp_encoder.sv
hw/uart_host_bridge.sv
tb/uart_host_bridge_assertions.sv
tb/tb_uart_host_bridge.sv

/* hw/hex_cmd_parser.sv */
// command parser: decodes ascii hex command frames into words for the bus master
`timescale 1ns/10ps
`default_nettype none

module hex_cmd_parser (
  input  logic                  clk,
  input  logic                  rst,
  input  uart_pkg::byte_t       i_byte,
  input  logic                  i_stb,
  input  logic                  i_master_ready,
  output host_proto_pkg::word_t  o_cmd_command,
  output host_proto_pkg::word_t  o_cmd_address,
  output host_proto_pkg::word_t  o_cmd_data,
  output host_proto_pkg::count_t o_cmd_count,
  output logic                  o_cmd_stb
);
  import host_proto_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_COUNT,
    ST_COMMAND,
    ST_ADDRESS,
    ST_DATA,
    ST_DELIVER
  } parse_state_t;

  parse_state_t state;
  parse_state_t next_field;
  logic [3:0]   nib_cnt;
  logic         field_last;
  count_t       word_cnt;
  logic         is_digit;
  logic         is_upper;
  logic         is_hex;
  nibble_t      nibble;
  logic         is_write;

  // only 0-9 and upper case A-F are legal
  assign is_digit = (i_byte >= CHAR_0) && (i_byte <= CHAR_0 + 8'd9);
  assign is_upper = (i_byte >= CHAR_A) && (i_byte <= CHAR_F);
  assign is_hex   = is_digit || is_upper;
  assign nibble   = is_digit ? nibble_t'(i_byte - CHAR_0) : nibble_t'(i_byte - CHAR_A + 8'd10);

  assign is_write  = (o_cmd_command[15:0] == CMD_WRITE[15:0]);
  assign o_cmd_stb = (state == ST_DELIVER) && i_master_ready;

  // count field is one digit shorter than the word fields
  assign field_last = (state == ST_COUNT) ? (nib_cnt == 4'(COUNT_DIGITS - 1)) :
                                            (nib_cnt == 4'(WORD_DIGITS - 1));

  always_comb begin
    case (state)
      ST_COUNT:   next_field = ST_COMMAND;
      ST_COMMAND: next_field = ST_ADDRESS;
      ST_ADDRESS: next_field = ST_DATA;
      default:    next_field = ST_DELIVER;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      nib_cnt  <= '0;
      word_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (i_stb && (i_byte == CHAR_L)) begin
            nib_cnt  <= '0;
            word_cnt <= '0;
            state    <= ST_COUNT;
          end
        end
        ST_COUNT, ST_COMMAND, ST_ADDRESS, ST_DATA: begin
          if (i_stb) begin
            if (!is_hex) begin
              // bad character drops the whole frame
              state <= ST_IDLE;
            end else if (field_last) begin
              nib_cnt <= '0;
              state   <= next_field;
              if (state == ST_DATA) begin
                word_cnt <= word_cnt + 1'b1;
              end
            end else begin
              nib_cnt <= nib_cnt + 1'b1;
            end
          end
        end
        ST_DELIVER: begin
          // writes loop back for the remaining data words
          if (i_master_ready) begin
            state <= (is_write && (word_cnt < o_cmd_count)) ? ST_DATA : ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // field shift registers, msb nibble first
  always_ff @(posedge clk) begin
    if (i_stb && is_hex) begin
      case (state)
        ST_COUNT:   o_cmd_count   <= {o_cmd_count[23:0], nibble};
        ST_COMMAND: o_cmd_command <= {o_cmd_command[27:0], nibble};
        ST_ADDRESS: o_cmd_address <= {o_cmd_address[27:0], nibble};
        ST_DATA:    o_cmd_data    <= {o_cmd_data[27:0], nibble};
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/hex_rsp_encoder.sv */
// response encoder: turns master responses into ascii hex characters for the FIFO
`timescale 1ns/10ps
`default_nettype none

module hex_rsp_encoder (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_rsp_en,
  input  host_proto_pkg::word_t  i_rsp_status,
  input  host_proto_pkg::word_t  i_rsp_address,
  input  host_proto_pkg::word_t  i_rsp_data,
  input  host_proto_pkg::count_t i_rsp_count,
  input  logic                   i_full,
  output logic                   o_push,
  output uart_pkg::byte_t        o_byte,
  output logic                   o_rsp_ready
);
  import host_proto_pkg::*;
  import uart_pkg::*;

  typedef enum logic [2:0] {
    ENC_IDLE,
    ENC_HEAD,
    ENC_COUNT,
    ENC_STATUS,
    ENC_ADDRESS,
    ENC_DATA,
    ENC_WAIT
  } enc_state_t;

  enc_state_t state;
  logic [3:0] nib_cnt;
  logic       count_last;
  logic       word_last;
  count_t     words_total;
  count_t     words_sent;
  count_t     count_sh;
  word_t      status_sh;
  word_t      address_sh;
  word_t      data_sh;

  function automatic byte_t hex_char(input nibble_t n);
    if (n < 4'd10) begin
      return byte_t'(CHAR_0 + {4'h0, n});
    end
    return byte_t'(CHAR_A + {4'h0, n} - 8'd10);
  endfunction

  assign count_last  = (nib_cnt == 4'(COUNT_DIGITS - 1));
  assign word_last   = (nib_cnt == 4'(WORD_DIGITS - 1));
  assign o_rsp_ready = (state == ENC_IDLE) || (state == ENC_WAIT);

  // full fifo simply holds the current character
  assign o_push = (state inside {ENC_HEAD, ENC_COUNT, ENC_STATUS, ENC_ADDRESS, ENC_DATA}) &&
                  !i_full;

  always_comb begin
    case (state)
      ENC_COUNT:   o_byte = hex_char(count_sh[27:24]);
      ENC_STATUS:  o_byte = hex_char(status_sh[31:28]);
      ENC_ADDRESS: o_byte = hex_char(address_sh[31:28]);
      ENC_DATA:    o_byte = hex_char(data_sh[31:28]);
      default:     o_byte = CHAR_S;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ENC_IDLE;
      nib_cnt    <= '0;
      words_sent <= '0;
    end else begin
      case (state)
        ENC_IDLE: begin
          if (i_rsp_en) begin
            nib_cnt    <= '0;
            words_sent <= '0;
            state      <= ENC_HEAD;
          end
        end
        ENC_HEAD: begin
          if (o_push) begin
            state <= ENC_COUNT;
          end
        end
        ENC_COUNT: begin
          if (o_push) begin
            nib_cnt <= count_last ? '0 : nib_cnt + 1'b1;
            if (count_last) begin
              state <= ENC_STATUS;
            end
          end
        end
        ENC_STATUS, ENC_ADDRESS: begin
          if (o_push) begin
            nib_cnt <= word_last ? '0 : nib_cnt + 1'b1;
            if (word_last) begin
              state <= (state == ENC_STATUS) ? ENC_ADDRESS : ENC_DATA;
            end
          end
        end
        ENC_DATA: begin
          if (o_push) begin
            nib_cnt <= word_last ? '0 : nib_cnt + 1'b1;
            if (word_last) begin
              words_sent <= words_sent + 1'b1;
              state      <= (words_sent == words_total - 1'b1) ? ENC_IDLE : ENC_WAIT;
            end
          end
        end
        ENC_WAIT: begin
          if (i_rsp_en) begin
            state <= ENC_DATA;
          end
        end
        default: state <= ENC_IDLE;
      endcase
    end
  end

  // latched response, shifted out msb nibble first
  always_ff @(posedge clk) begin
    if ((state == ENC_IDLE) && i_rsp_en) begin
      count_sh    <= i_rsp_count;
      status_sh   <= i_rsp_status;
      address_sh  <= i_rsp_address;
      data_sh     <= i_rsp_data;
      // a zero count still carries one word
      words_total <= (i_rsp_count == '0) ? count_t'(1) : i_rsp_count;
    end else if ((state == ENC_WAIT) && i_rsp_en) begin
      data_sh <= i_rsp_data;
    end else if (o_push) begin
      case (state)
        ENC_COUNT:   count_sh   <= {count_sh[23:0], 4'h0};
        ENC_STATUS:  status_sh  <= {status_sh[27:0], 4'h0};
        ENC_ADDRESS: address_sh <= {address_sh[27:0], 4'h0};
        ENC_DATA:    data_sh    <= {data_sh[27:0], 4'h0};
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/host_proto_pkg.sv */
// host frame protocol package: field types, command codes and frame characters
`default_nettype none

package host_proto_pkg;

  // frame field types
  typedef logic [31:0] word_t;
  typedef logic [27:0] count_t;
  typedef logic [3:0]  nibble_t;

  // compared against the low 16 bits of the command word
  localparam word_t CMD_WRITE = 32'h0000_0001;
  localparam word_t CMD_READ  = 32'h0000_0002;

  // frame characters
  localparam logic [7:0] CHAR_L = 8'h4C;
  localparam logic [7:0] CHAR_S = 8'h53;
  localparam logic [7:0] CHAR_0 = 8'h30;
  localparam logic [7:0] CHAR_A = 8'h41;
  localparam logic [7:0] CHAR_F = 8'h46;

  // hex characters per field
  localparam int COUNT_DIGITS = 7;
  localparam int WORD_DIGITS  = 8;

endpackage

`default_nettype wire

/* hw/tx_char_fifo.sv */
// character FIFO: circular buffer between the response encoder and the transmitter
`timescale 1ns/10ps
`default_nettype none

module tx_char_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            i_push,
  input  uart_pkg::byte_t i_byte,
  input  logic            i_pop,
  output uart_pkg::byte_t o_byte,
  output logic            o_empty,
  output logic            o_full
);
  import uart_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  byte_t            mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             wr_en;
  logic             rd_en;

  assign wr_en   = i_push && !o_full;
  assign rd_en   = i_pop && !o_empty;
  assign o_empty = (count == '0);
  assign o_full  = (count == (PTR_W + 1)'(FIFO_DEPTH));

  // head shows through without a read cycle
  assign o_byte = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_byte;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/uart_host_bridge.sv */
// uart host bridge top: receiver, command parser, response encoder, FIFO and transmitter
`timescale 1ns/10ps
`default_nettype none

module uart_host_bridge #(
  parameter int CLKS_PER_BIT = 8,
  parameter int FIFO_DEPTH   = 16
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_uart_rx,
  output logic                   o_uart_tx,
  input  logic                   i_master_ready,
  output host_proto_pkg::word_t  o_cmd_command,
  output host_proto_pkg::word_t  o_cmd_address,
  output host_proto_pkg::word_t  o_cmd_data,
  output host_proto_pkg::count_t o_cmd_count,
  output logic                   o_cmd_stb,
  input  logic                   i_rsp_en,
  input  host_proto_pkg::word_t  i_rsp_status,
  input  host_proto_pkg::word_t  i_rsp_address,
  input  host_proto_pkg::word_t  i_rsp_data,
  input  host_proto_pkg::count_t i_rsp_count,
  output logic                   o_rsp_ready
);
  import uart_pkg::*;

  byte_t rx_byte;
  logic  rx_stb;
  byte_t enc_byte;
  logic  enc_push;
  byte_t fifo_byte;
  logic  fifo_empty;
  logic  fifo_full;
  logic  tx_pop;

  // receive path
  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_receiver (
    .clk(clk), .rst(rst), .i_rx(i_uart_rx), .o_byte(rx_byte), .o_stb(rx_stb)
  );

  hex_cmd_parser i_cmd_parser (
    .clk(clk), .rst(rst), .i_byte(rx_byte), .i_stb(rx_stb),
    .i_master_ready(i_master_ready), .o_cmd_command(o_cmd_command),
    .o_cmd_address(o_cmd_address), .o_cmd_data(o_cmd_data),
    .o_cmd_count(o_cmd_count), .o_cmd_stb(o_cmd_stb)
  );

  // transmit path
  hex_rsp_encoder i_rsp_encoder (
    .clk(clk), .rst(rst), .i_rsp_en(i_rsp_en), .i_rsp_status(i_rsp_status),
    .i_rsp_address(i_rsp_address), .i_rsp_data(i_rsp_data),
    .i_rsp_count(i_rsp_count), .i_full(fifo_full), .o_push(enc_push),
    .o_byte(enc_byte), .o_rsp_ready(o_rsp_ready)
  );

  tx_char_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_char_fifo (
    .clk(clk), .rst(rst), .i_push(enc_push), .i_byte(enc_byte), .i_pop(tx_pop),
    .o_byte(fifo_byte), .o_empty(fifo_empty), .o_full(fifo_full)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_transmitter (
    .clk(clk), .rst(rst), .i_empty(fifo_empty), .i_byte(fifo_byte),
    .o_pop(tx_pop), .o_tx(o_uart_tx)
  );

endmodule

`default_nettype wire

/* hw/uart_pkg.sv */
// serial side package: character and bit timing counter types
`default_nettype none

package uart_pkg;

  // one serial character
  typedef logic [7:0] byte_t;

  // counts clocks within one bit time
  typedef logic [15:0] baud_cnt_t;

endpackage

`default_nettype wire

/* hw/uart_rx.sv */
// serial receiver: samples each bit at mid-bit and strobes every received byte
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            i_rx,
  output uart_pkg::byte_t o_byte,
  output logic            o_stb
);
  import uart_pkg::*;

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t state;
  logic      rx_meta;
  logic      rx_sync;
  baud_cnt_t baud_cnt;
  logic      half_done;
  logic      bit_done;
  logic [2:0] bit_idx;
  byte_t     shift;

  assign half_done = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT / 2 - 1));
  assign bit_done  = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));

  // two flop synchronizer, idles high
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= i_rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk) begin
    o_stb <= 1'b0;
    if (rst) begin
      state    <= RX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else begin
      case (state)
        RX_IDLE: begin
          baud_cnt <= '0;
          if (!rx_sync) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // recheck at mid start bit, glitches fall back to idle
          if (half_done) begin
            baud_cnt <= '0;
            bit_idx  <= '0;
            state    <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_done) begin
            baud_cnt <= '0;
            // lsb arrives first
            shift    <= {rx_sync, shift[7:1]};
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_done) begin
            baud_cnt <= '0;
            state    <= RX_IDLE;
            if (rx_sync) begin
              o_stb  <= 1'b1;
              o_byte <= shift;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/uart_tx.sv */
// serial transmitter: pulls characters from the FIFO and shifts them out lsb first
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            i_empty,
  input  uart_pkg::byte_t i_byte,
  output logic            o_pop,
  output logic            o_tx
);
  import uart_pkg::*;

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

  tx_state_t  state;
  baud_cnt_t  baud_cnt;
  logic       bit_done;
  logic [2:0] bit_idx;
  byte_t      shift;

  assign bit_done = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));

  // fifo head is valid in the pop cycle
  assign o_pop = (state == TX_IDLE) && !i_empty;

  always_comb begin
    case (state)
      TX_START: o_tx = 1'b0;
      TX_DATA:  o_tx = shift[0];
      default:  o_tx = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= TX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else begin
      baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
      case (state)
        TX_IDLE: begin
          baud_cnt <= '0;
          if (o_pop) begin
            shift <= i_byte;
            state <= TX_START;
          end
        end
        TX_START: begin
          if (bit_done) begin
            bit_idx <= '0;
            state   <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (bit_done) begin
            shift   <= {1'b1, shift[7:1]};
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= TX_STOP;
            end
          end
        end
        TX_STOP: begin
          if (bit_done) begin
            state <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* tb/bridge_trace.txt */
# T name | H host chars up to ';' | C command address data count (expected strobe)
# R status address data count (master response word) | E expected response chars up to ';'
T single_write
H L 0000001 00000001 10002000 DEADBEEF ;
C 00000001 10002000 DEADBEEF 0000001
R 00000000 10002000 00000000 0000001
E S 0000001 00000000 10002000 00000000 ;
T write_burst
H L 0000003 00000001 20000040 11111111 22222222 33333333 ;
C 00000001 20000040 11111111 0000003
C 00000001 20000040 22222222 0000003
C 00000001 20000040 33333333 0000003
E ;
T bad_char
H L 0000001 0000a001 L 000G L 0000001 00000001 30000000 CAFEF00D ;
C 00000001 30000000 CAFEF00D 0000001
E ;
T read_single
H L 0000004 00000002 40000100 00000000 ;
C 00000002 40000100 00000000 0000004
R 00000000 40000100 0BADC0DE 0000001
E S 0000001 00000000 40000100 0BADC0DE ;
T read_burst
H L 0000004 00000002 50000000 00000000 ;
C 00000002 50000000 00000000 0000004
R 0000000A 50000000 01234567 0000004
R 0000000A 50000000 89ABCDEF 0000004
R 0000000A 50000000 FEDCBA98 0000004
R 0000000A 50000000 76543210 0000004
E S 0000004 0000000A 50000000 01234567 89ABCDEF FEDCBA98 76543210 ;

/* tb/tb_uart_host_bridge.sv */
// uart host bridge testbench: plays the host serial line and the bus master from a trace file
`timescale 1ns/10ps
`default_nettype none

module tb_uart_host_bridge;
  import host_proto_pkg::*;
  import uart_pkg::*;

  localparam int CLKS_PER_BIT = 8;
  localparam int FIFO_DEPTH   = 16;
  localparam int RESET_CYCLES = 16;

  logic   clk;
  logic   rst;
  logic   uart_rx;
  logic   uart_tx;
  logic   master_ready;
  word_t  cmd_command;
  word_t  cmd_address;
  word_t  cmd_data;
  count_t cmd_count;
  logic   cmd_stb;
  logic   rsp_en;
  word_t  rsp_status;
  word_t  rsp_address;
  word_t  rsp_data;
  count_t rsp_count;
  logic   rsp_ready;

  // trace contents, one entry per test
  string  test_names[$];
  string  host_strs[$];
  string  exp_strs[$];
  int     n_cmd[$];
  int     n_rsp[$];
  // expected strobes and master responses, flat over all tests
  word_t  exp_cmd_q[$];
  word_t  exp_addr_q[$];
  word_t  exp_data_q[$];
  count_t exp_cnt_q[$];
  word_t  rsp_status_q[$];
  word_t  rsp_addr_q[$];
  word_t  rsp_data_q[$];
  count_t rsp_cnt_q[$];

  // what the DUT produced during the current test
  word_t  cap_cmd[$];
  word_t  cap_addr[$];
  word_t  cap_data[$];
  count_t cap_cnt[$];
  byte_t  tx_chars[$];

  int errors;
  int tests_run;
  int tests_failed;
  int total_chars;

  uart_host_bridge #(
    .CLKS_PER_BIT(CLKS_PER_BIT),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) i_uart_host_bridge (
    .clk(clk), .rst(rst), .i_uart_rx(uart_rx), .o_uart_tx(uart_tx),
    .i_master_ready(master_ready), .o_cmd_command(cmd_command),
    .o_cmd_address(cmd_address), .o_cmd_data(cmd_data), .o_cmd_count(cmd_count),
    .o_cmd_stb(cmd_stb), .i_rsp_en(rsp_en), .i_rsp_status(rsp_status),
    .i_rsp_address(rsp_address), .i_rsp_data(rsp_data), .i_rsp_count(rsp_count),
    .o_rsp_ready(rsp_ready)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic skip_line(input int fd);
    int c;
    c = $fgetc(fd);
    while (c != 10 && c != -1) begin
      c = $fgetc(fd);
    end
  endtask

  // character groups run up to a lone ';'
  task automatic read_chars(input int fd, output string chars);
    string tok;
    int    rc;
    chars = "";
    rc = $fscanf(fd, "%s", tok);
    while (rc == 1 && tok != ";") begin
      chars = {chars, tok};
      rc = $fscanf(fd, "%s", tok);
    end
  endtask

  task automatic load_trace(input int fd);
    string  tag;
    string  tok;
    int     rc;
    int     idx;
    word_t  a;
    word_t  b;
    word_t  c;
    count_t n;
    idx = -1;
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag == "#") begin
        skip_line(fd);
      end else if (tag == "T") begin
        rc = $fscanf(fd, "%s", tok);
        test_names.push_back(tok);
        host_strs.push_back("");
        exp_strs.push_back("");
        n_cmd.push_back(0);
        n_rsp.push_back(0);
        idx++;
      end else if (tag == "H" || tag == "E") begin
        read_chars(fd, tok);
        total_chars += tok.len();
        if (tag == "H") begin
          host_strs[idx] = tok;
        end else begin
          exp_strs[idx] = tok;
        end
      end else if (tag == "C" || tag == "R") begin
        rc = $fscanf(fd, "%h %h %h %h", a, b, c, n);
        if (rc != 4) begin
          $display("trace record %s of test %0d has too few fields", tag, idx);
          errors++;
        end
        if (tag == "C") begin
          exp_cmd_q.push_back(a);
          exp_addr_q.push_back(b);
          exp_data_q.push_back(c);
          exp_cnt_q.push_back(n);
          n_cmd[idx]++;
        end else begin
          rsp_status_q.push_back(a);
          rsp_addr_q.push_back(b);
          rsp_data_q.push_back(c);
          rsp_cnt_q.push_back(n);
          n_rsp[idx]++;
        end
      end else begin
        $display("unknown record '%s' in the trace file", tag);
        errors++;
      end
    end
  endtask

  // start bit, 8 data bits lsb first, stop bit
  task automatic send_char(input byte_t c);
    logic [9:0] frame;
    frame = {1'b1, c, 1'b0};
    for (int b = 0; b < 10; b++) begin
      @(posedge clk);
      uart_rx <= frame[b];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  // ready is sampled mid cycle, the strobe goes out on the next rising edge
  task automatic send_response(input word_t status, input word_t address,
                               input word_t data, input count_t count);
    @(negedge clk);
    while (rsp_ready !== 1'b1) begin
      @(negedge clk);
    end
    @(posedge clk);
    rsp_en      <= 1'b1;
    rsp_status  <= status;
    rsp_address <= address;
    rsp_data    <= data;
    rsp_count   <= count;
    @(posedge clk);
    rsp_en <= 1'b0;
  endtask

  // bus master side, ready is held high
  always @(negedge clk) begin
    if (!rst && cmd_stb === 1'b1) begin
      cap_cmd.push_back(cmd_command);
      cap_addr.push_back(cmd_address);
      cap_data.push_back(cmd_data);
      cap_cnt.push_back(cmd_count);
    end
  end

  always begin : serial_monitor
    byte_t ch;
    @(negedge clk);
    if (!rst && uart_tx === 1'b0) begin
      // move to mid start bit, then one bit time per sample
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      for (int b = 0; b < 8; b++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        ch = {uart_tx, ch[7:1]};
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      check_value("o_uart_tx stop bit", uart_tx, 32'h1);
      tx_chars.push_back(ch);
    end
  end

  task automatic run_test(input int idx);
    int     errs_before;
    int     n_exp;
    string  host;
    string  exp_str;
    word_t  e_cmd;
    word_t  e_addr;
    word_t  e_data;
    count_t e_cnt;
    errs_before = errors;
    host        = host_strs[idx];
    exp_str     = exp_strs[idx];
    n_exp       = n_cmd[idx];
    cap_cmd.delete();
    cap_addr.delete();
    cap_data.delete();
    cap_cnt.delete();
    tx_chars.delete();
    for (int i = 0; i < host.len(); i++) begin
      send_char(host[i]);
    end
    while (cap_cmd.size() < n_exp) begin
      @(negedge clk);
    end
    for (int r = 0; r < n_rsp[idx]; r++) begin
      send_response(rsp_status_q.pop_front(), rsp_addr_q.pop_front(),
                    rsp_data_q.pop_front(), rsp_cnt_q.pop_front());
    end
    while (tx_chars.size() < exp_str.len()) begin
      @(negedge clk);
    end
    // one more character time to catch stray strobes or characters
    repeat (10 * CLKS_PER_BIT) @(negedge clk);
    check_value("o_cmd_stb count", cap_cmd.size(), n_exp);
    for (int k = 0; k < n_exp; k++) begin
      e_cmd  = exp_cmd_q.pop_front();
      e_addr = exp_addr_q.pop_front();
      e_data = exp_data_q.pop_front();
      e_cnt  = exp_cnt_q.pop_front();
      if (k < cap_cmd.size()) begin
        check_value("o_cmd_command", cap_cmd[k], e_cmd);
        check_value("o_cmd_address", cap_addr[k], e_addr);
        check_value("o_cmd_data", cap_data[k], e_data);
        check_value("o_cmd_count", cap_cnt[k], e_cnt);
      end
    end
    check_value("o_uart_tx character count", tx_chars.size(), exp_str.len());
    for (int k = 0; k < exp_str.len() && k < tx_chars.size(); k++) begin
      check_value($sformatf("o_uart_tx character %0d", k), tx_chars[k], exp_str[k]);
    end
    tests_run++;
    if (errors == errs_before) begin
      $display("test %-14s ok", test_names[idx]);
    end else begin
      tests_failed++;
      $display("test %-14s mismatch", test_names[idx]);
    end
  endtask

  initial begin
    int fd;
    int limit;
    rst          = 1'b1;
    uart_rx      = 1'b1;
    master_ready = 1'b1;
    rsp_en       = 1'b0;
    rsp_status   = '0;
    rsp_address  = '0;
    rsp_data     = '0;
    rsp_count    = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    total_chars  = 0;
    fd = $fopen("tb/bridge_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open tb/bridge_trace.txt, no tests were run");
      errors++;
    end else begin
      load_trace(fd);
      $fclose(fd);
      // every character at 10 bits, doubled for margin
      limit = total_chars * 10 * CLKS_PER_BIT * 2 + RESET_CYCLES;
      fork
        begin
          repeat (limit) @(posedge clk);
          $display("timeout: tests did not finish within %0d cycles", limit);
          $display("FAIL: see errors above");
          $finish;
        end
      join_none
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_value("o_uart_tx", uart_tx, 32'h1);
      check_value("o_rsp_ready", rsp_ready, 32'h1);
      check_value("o_cmd_stb", cmd_stb, 32'h0);
      tests_run++;
      if (errors == 0) begin
        $display("test %-14s ok", "reset_state");
      end else begin
        tests_failed++;
        $display("test %-14s mismatch", "reset_state");
      end
      for (int t = 0; t < test_names.size(); t++) begin
        run_test(t);
      end
    end
    // bound assertions count their own failures
    if (i_uart_host_bridge.i_bridge_assertions.fail_count != 0) begin
      $display("%0d assertion failures were reported during the run",
               i_uart_host_bridge.i_bridge_assertions.fail_count);
      errors += i_uart_host_bridge.i_bridge_assertions.fail_count;
    end
    $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/uart_host_bridge_assertions.sv */
// bridge assertions: command strobe width, idle line in reset and FIFO push against full
`timescale 1ns/10ps
`default_nettype none

module uart_host_bridge_assertions (
  input logic clk,
  input logic rst,
  input logic i_cmd_stb,
  input logic i_uart_tx,
  input logic i_push,
  input logic i_full
);

  // number of assertion failures so far
  int fail_count = 0;

  // one strobe per command word
  a_stb_single: assert property (@(posedge clk) disable iff (rst) i_cmd_stb |=> !i_cmd_stb)
    else begin
      fail_count++;
      $error("o_cmd_stb high two cycles running");
    end

  // line settles high after the first reset edge
  a_tx_idle: assert property (@(posedge clk) rst ##1 rst |-> i_uart_tx)
    else begin
      fail_count++;
      $error("o_uart_tx low while rst is high");
    end

  a_no_push_full: assert property (@(posedge clk) disable iff (rst) i_full |-> !i_push)
    else begin
      fail_count++;
      $error("character FIFO pushed while full");
    end

endmodule

// FIFO signals are the top level wires into tx_char_fifo
bind uart_host_bridge uart_host_bridge_assertions i_bridge_assertions (
  .clk(clk), .rst(rst), .i_cmd_stb(o_cmd_stb), .i_uart_tx(o_uart_tx),
  .i_push(enc_push), .i_full(fifo_full)
);

`default_nettype wire
